// ==== rtl/ahb_params.svh ====
/*
 * AHB subsystem parameters
 * Bus widths, slave count and per-slave memory depth
 */
`ifndef AHB_PARAMS_SVH
`define AHB_PARAMS_SVH

// **********************************************************************
// Bus widths
// **********************************************************************
`define AHB_ADDR_W       32           // HADDR width
`define AHB_DATA_W       32           // HWDATA / HRDATA width

// **********************************************************************
// Slave map
// **********************************************************************
`define AHB_NUM_SLV      4            // Slaves behind the decoder
`define AHB_SLV_SEL_LSB  8            // Select field starts at haddr[8]
`define AHB_SLV_WORDS    64           // Words per SRAM slave

`endif

// ==== rtl/ahb_pkg.sv ====
/*
 * AHB bus protocol types
 * Address and data words, transfer type and transfer size encodings
 */
`include "ahb_params.svh"

package ahb_pkg;

    // Bus words
    typedef logic [`AHB_ADDR_W-1:0] haddr_t;   // Full byte address
    typedef logic [`AHB_DATA_W-1:0] hdata_t;   // One bus word

    // HTRANS encoding, only IDLE and NONSEQ are ever driven
    typedef enum logic [1:0] {
        TRANS_IDLE   = 2'b00,                  // No transfer
        TRANS_NONSEQ = 2'b10                   // Single transfer
    } htrans_t;

    // HSIZE encoding
    typedef enum logic [2:0] {
        SIZE_BYTE = 3'b000,                    // 8 bits
        SIZE_HALF = 3'b001,                    // 16 bits
        SIZE_WORD = 3'b010                     // 32 bits, the only size used
    } hsize_t;

endpackage

// ==== rtl/xact_pkg.sv ====
/*
 * User transaction types
 * Operation code and the master / slave state encodings
 */
`include "ahb_params.svh"

package xact_pkg;

    // User read-or-write flag
    typedef enum logic {
        OP_READ  = 1'b0,                       // Read request
        OP_WRITE = 1'b1                        // Write request
    } op_t;

    // Master data-phase tracking
    typedef enum logic {
        M_IDLE = 1'b0,                         // No data phase pending
        M_BUSY = 1'b1                          // Data phase in flight
    } mst_state_t;

    // Slave wait-state tracking
    typedef enum logic {
        S_IDLE = 1'b0,                         // Ready, hreadyout high
        S_WAIT = 1'b1                          // Inserting wait states
    } slv_state_t;

endpackage

// ==== rtl/ahb_if.sv ====
/*
 * Shared AHB-Lite bus between master, decoder, slaves and response mux
 */
`timescale 1ns/1ps
`include "ahb_params.svh"

interface ahb_if;
    import ahb_pkg::*;

    // Master-driven address and control
    haddr_t  haddr;                            // Transfer address
    htrans_t htrans;                           // IDLE or NONSEQ
    logic    hwrite;                           // 1 = write
    hsize_t  hsize;                            // Always word
    hdata_t  hwdata;                           // Write data, data phase

    // Decode and per-slave response
    logic [`AHB_NUM_SLV-1:0] hsel;             // One-hot slave select
    logic    hreadyout_s [`AHB_NUM_SLV];       // Per-slave ready
    hdata_t  hrdata_s    [`AHB_NUM_SLV];       // Per-slave read data

    // Merged response back to master and slaves
    logic    hready;
    hdata_t  hrdata;

    modport master  (output haddr, htrans, hwrite, hsize, hwdata,
                     input  hready, hrdata);
    modport decoder (input  haddr, htrans,
                     output hsel);
    modport slave   (input  haddr, htrans, hwrite, hsize, hwdata, hsel, hready,
                     output hreadyout_s, hrdata_s);
    modport mux     (input  hsel, htrans, hreadyout_s, hrdata_s,
                     output hready, hrdata);

endinterface

// ==== rtl/ahb_master.sv ====
/*
 * AHB-Lite master
 * Turns single user requests into pipelined address and data phases,
 * holds a stalled address phase and returns read data to the user port
 */
`timescale 1ns/1ps

module ahb_master (
    input  logic             i_clk_ahb,
    input  logic             i_rstn_ahb,
    input  logic             i_valid,          // Request strobe
    input  xact_pkg::op_t    i_rd0_wr1,        // Read or write
    input  ahb_pkg::haddr_t  i_addr,
    input  ahb_pkg::hdata_t  i_wr_data,
    output logic             o_ready,          // Request taken when high
    output logic             o_rd_valid,       // Read data strobe
    output ahb_pkg::hdata_t  o_rd_data,
    ahb_if.master            bus
);
    import ahb_pkg::*;
    import xact_pkg::*;

    mst_state_t state_q;                       // Data phase pending

    // Data phase of the transfer in flight
    op_t        dp_op_q;
    hdata_t     dp_wdata_q;

    // Address phase held across a stall
    logic       hold_vld_q;
    haddr_t     hold_addr_q;
    op_t        hold_op_q;
    hdata_t     hold_wdata_q;

    // Address phase currently on the bus
    logic       ap_req;
    haddr_t     ap_addr;
    op_t        ap_op;
    hdata_t     ap_wdata;
    logic       ap_taken;
    logic       dp_done;

    // **********************************************************************
    // Address phase source
    // **********************************************************************
    assign ap_req   = hold_vld_q | i_valid;                    // Held wins
    assign ap_addr  = hold_vld_q ? hold_addr_q  : i_addr;
    assign ap_op    = hold_vld_q ? hold_op_q    : i_rd0_wr1;
    assign ap_wdata = hold_vld_q ? hold_wdata_q : i_wr_data;
    assign ap_taken = ap_req & bus.hready;                     // Sampled by slave
    assign dp_done  = (state_q == M_BUSY) & bus.hready;        // Data phase ends

    assign bus.htrans = ap_req ? TRANS_NONSEQ : TRANS_IDLE;
    assign bus.haddr  = ap_addr;
    assign bus.hwrite = (ap_op == OP_WRITE);
    assign bus.hsize  = SIZE_WORD;
    assign bus.hwdata = dp_wdata_q;                            // One cycle behind addr

    // User side follows the bus
    assign o_ready    = bus.hready;
    assign o_rd_valid = dp_done & (dp_op_q == OP_READ);
    assign o_rd_data  = bus.hrdata;

    // **********************************************************************
    // Data phase FSM
    // **********************************************************************
    always_ff @(posedge i_clk_ahb or negedge i_rstn_ahb) begin
        if (!i_rstn_ahb) begin
            state_q <= M_IDLE;
        end else if (ap_taken) begin
            state_q <= M_BUSY;                 // New data phase next cycle
        end else if (bus.hready) begin
            state_q <= M_IDLE;                 // Drained, nothing behind it
        end
    end

    always_ff @(posedge i_clk_ahb) begin
        if (ap_taken) begin
            dp_op_q    <= ap_op;
            dp_wdata_q <= ap_wdata;
        end
    end

    // Stall holding of the pending address phase
    always_ff @(posedge i_clk_ahb or negedge i_rstn_ahb) begin
        if (!i_rstn_ahb) begin
            hold_vld_q <= 1'b0;
        end else if (bus.hready) begin
            hold_vld_q <= 1'b0;                // Taken this edge
        end else if (ap_req) begin
            hold_vld_q <= 1'b1;
        end
    end

    always_ff @(posedge i_clk_ahb) begin
        if (!bus.hready && !hold_vld_q) begin
            hold_addr_q  <= i_addr;            // First stall cycle only
            hold_op_q    <= i_rd0_wr1;
            hold_wdata_q <= i_wr_data;
        end
    end

    // **********************************************************************
    // Checks
    // **********************************************************************
    a_stall_stable: assert property (
        @(posedge i_clk_ahb) disable iff (!i_rstn_ahb)
        (bus.htrans == TRANS_NONSEQ && !bus.hready) |=>
            (bus.htrans == TRANS_NONSEQ && $stable(bus.haddr) && $stable(bus.hwrite))
    ) else $error("address phase changed during stall");

endmodule

// ==== rtl/ahb_decoder.sv ====
/*
 * AHB address decoder
 * One-hot slave select from haddr[9:8], only for NONSEQ transfers
 */
`timescale 1ns/1ps
`include "ahb_params.svh"

module ahb_decoder (
    ahb_if.decoder bus
);
    import ahb_pkg::*;

    localparam int SEL_W = $clog2(`AHB_NUM_SLV);   // Select field width

    logic [SEL_W-1:0] slv_idx;

    // Higher address bits are ignored, so regions alias
    assign slv_idx = bus.haddr[`AHB_SLV_SEL_LSB +: SEL_W];

    always_comb begin
        bus.hsel = '0;                         // Nothing selected on IDLE
        if (bus.htrans == TRANS_NONSEQ) begin
            bus.hsel[slv_idx] = 1'b1;
        end
    end

endmodule

// ==== rtl/ahb_sram_slave.sv ====
/*
 * AHB word SRAM slave
 * Captures the address phase when selected, inserts WAIT_STATES wait
 * cycles, then writes memory or returns the stored word
 */
`timescale 1ns/1ps
`include "ahb_params.svh"

module ahb_sram_slave #(
    parameter int SLV_ID      = 0,             // Element of the response arrays
    parameter int WAIT_STATES = 0              // hreadyout low cycles per transfer
) (
    input  logic  i_clk_ahb,
    input  logic  i_rstn_ahb,
    ahb_if.slave  bus
);
    import ahb_pkg::*;
    import xact_pkg::*;

    localparam int WORD_AW = $clog2(`AHB_SLV_WORDS);
    localparam int CNT_W   = (WAIT_STATES > 1) ? $clog2(WAIT_STATES) : 1;

    hdata_t           mem [`AHB_SLV_WORDS];    // Storage
    slv_state_t       state_q;
    logic [CNT_W-1:0] wait_cnt_q;              // Wait cycles left minus one
    logic             dp_act_q;                // Own data phase in progress
    logic [WORD_AW-1:0] word_q;                // Captured word index
    logic             wr_q;                    // Captured hwrite
    logic             sel_ap;
    logic             dp_done;

    assign sel_ap  = bus.hsel[SLV_ID] & (bus.htrans == TRANS_NONSEQ) & bus.hready;
    assign dp_done = dp_act_q & (state_q == S_IDLE);   // Final data cycle

    // **********************************************************************
    // Wait-state FSM
    // **********************************************************************
    always_ff @(posedge i_clk_ahb or negedge i_rstn_ahb) begin
        if (!i_rstn_ahb) begin
            state_q    <= S_IDLE;
            wait_cnt_q <= '0;
            dp_act_q   <= 1'b0;
        end else begin
            if (sel_ap) begin
                dp_act_q <= 1'b1;
            end else if (dp_done) begin
                dp_act_q <= 1'b0;
            end
            if (sel_ap && WAIT_STATES != 0) begin
                state_q    <= S_WAIT;
                wait_cnt_q <= CNT_W'(WAIT_STATES - 1);
            end else if (state_q == S_WAIT) begin
                if (wait_cnt_q == '0) begin
                    state_q <= S_IDLE;         // Ready next cycle
                end else begin
                    wait_cnt_q <= wait_cnt_q - 1'b1;
                end
            end
        end
    end

    // Address phase capture, bits 7:2 pick the word
    always_ff @(posedge i_clk_ahb) begin
        if (sel_ap) begin
            word_q <= bus.haddr[2 +: WORD_AW];
            wr_q   <= bus.hwrite;
        end
    end

    // Write lands on the completing edge
    always_ff @(posedge i_clk_ahb) begin
        if (dp_done && wr_q) begin
            mem[word_q] <= bus.hwdata;
        end
    end

    assign bus.hreadyout_s[SLV_ID] = (state_q != S_WAIT);
    assign bus.hrdata_s[SLV_ID]    = mem[word_q];     // Mux picks it when owner

    // Only word transfers are supported by this memory
    a_word_only: assert property (
        @(posedge i_clk_ahb) disable iff (!i_rstn_ahb)
        (bus.hsel[SLV_ID] && bus.htrans == TRANS_NONSEQ) |-> (bus.hsize == SIZE_WORD)
    ) else $error("slave %0d: non-word transfer", SLV_ID);

endmodule

// ==== rtl/ahb_resp_mux.sv ====
/*
 * AHB response multiplexer
 * Tracks which slave owns the data phase and returns its ready and data
 */
`timescale 1ns/1ps
`include "ahb_params.svh"

module ahb_resp_mux (
    input  logic  i_clk_ahb,
    input  logic  i_rstn_ahb,
    ahb_if.mux    bus
);
    import ahb_pkg::*;

    localparam int SEL_W = $clog2(`AHB_NUM_SLV);

    logic             dp_act_q;                // Data phase active
    logic [SEL_W-1:0] owner_q;                 // Slave owning the data phase
    logic [SEL_W-1:0] sel_idx;                 // Encoded hsel

    // One-hot to index
    always_comb begin
        sel_idx = '0;
        for (int i = 0; i < `AHB_NUM_SLV; i++) begin
            if (bus.hsel[i]) begin
                sel_idx = SEL_W'(i);
            end
        end
    end

    // Owner moves only when an address phase is taken
    always_ff @(posedge i_clk_ahb or negedge i_rstn_ahb) begin
        if (!i_rstn_ahb) begin
            dp_act_q <= 1'b0;
            owner_q  <= '0;
        end else if (bus.hready) begin
            dp_act_q <= (bus.htrans == TRANS_NONSEQ);
            if (bus.htrans == TRANS_NONSEQ) begin
                owner_q <= sel_idx;
            end
        end
    end

    assign bus.hready = dp_act_q ? bus.hreadyout_s[owner_q] : 1'b1;  // Idle bus is ready
    assign bus.hrdata = bus.hrdata_s[owner_q];

    // Encoder above needs exactly one select per NONSEQ, none on IDLE
    a_hsel_onehot: assert property (
        @(posedge i_clk_ahb) disable iff (!i_rstn_ahb)
        (bus.htrans == TRANS_NONSEQ) ? $onehot(bus.hsel) : (bus.hsel == '0)
    ) else $error("hsel not one-hot: %b", bus.hsel);

endmodule

// ==== rtl/ahb_subsys_top.sv ====
/*
 * AHB-Lite memory subsystem top level
 * Master, decoder, four SRAM slaves with 0..3 wait states, response mux
 */
`timescale 1ns/1ps
`include "ahb_params.svh"

module ahb_subsys_top (
    input  logic             i_clk_ahb,
    input  logic             i_rstn_ahb,
    input  logic             i_valid,
    input  xact_pkg::op_t    i_rd0_wr1,
    input  ahb_pkg::haddr_t  i_addr,
    input  ahb_pkg::hdata_t  i_wr_data,
    output logic             o_ready,
    output logic             o_rd_valid,
    output ahb_pkg::hdata_t  o_rd_data
);

    ahb_if u_bus ();                           // Shared bus

    ahb_master u_master (
        .i_clk_ahb  (i_clk_ahb),
        .i_rstn_ahb (i_rstn_ahb),
        .i_valid    (i_valid),
        .i_rd0_wr1  (i_rd0_wr1),
        .i_addr     (i_addr),
        .i_wr_data  (i_wr_data),
        .o_ready    (o_ready),
        .o_rd_valid (o_rd_valid),
        .o_rd_data  (o_rd_data),
        .bus        (u_bus.master)
    );

    ahb_decoder u_dec (.bus(u_bus.decoder));

    // Slave k inserts k wait states
    for (genvar k = 0; k < `AHB_NUM_SLV; k++) begin : g_slv
        ahb_sram_slave #(.SLV_ID(k), .WAIT_STATES(k)) u_slv (
            .i_clk_ahb  (i_clk_ahb),
            .i_rstn_ahb (i_rstn_ahb),
            .bus        (u_bus.slave)
        );
    end

    ahb_resp_mux u_mux (
        .i_clk_ahb  (i_clk_ahb),
        .i_rstn_ahb (i_rstn_ahb),
        .bus        (u_bus.mux)
    );

endmodule

// ==== tests/tb_clkgen.sv ====
/*
 * Testbench clock and reset generator
 * 4 ns clock, active-low reset held for 16 cycles
 */
`timescale 1ns/1ps

module tb_clkgen (
    output logic o_clk_ahb,
    output logic o_rstn_ahb
);
    localparam int RST_CYCLES = 16;

    initial begin
        o_clk_ahb = 1'b0;
        forever #2 o_clk_ahb = ~o_clk_ahb;     // 4 ns period
    end

    initial begin
        o_rstn_ahb = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk_ahb);
        @(negedge o_clk_ahb);
        o_rstn_ahb = 1'b1;                     // Released mid-cycle
    end

endmodule

// ==== tests/tb_ahb_subsys.sv ====
/*
 * AHB subsystem testbench
 * Directed and LFSR-random user requests, reference memory and a
 * cycle model of ready and read-valid timing per slave
 */
`timescale 1ns/1ps
`include "ahb_params.svh"

module tb_ahb_subsys;
    import ahb_pkg::*;
    import xact_pkg::*;

    localparam int N_DIRECT = 8 + 8 + 40;      // Zero reads, write/read, alias
    localparam int N_RAND   = 200;             // Random valid level
    localparam int N_B2B    = 200;             // Valid held high
    localparam int N_DRAIN  = 8;
    localparam int N_TXN    = N_DIRECT + N_RAND + N_B2B + N_DRAIN;
    localparam int TIMEOUT_CYC = N_TXN * (`AHB_NUM_SLV + 2) + 16 + 50;

    logic   clk_ahb;
    logic   rstn_ahb;
    logic   req_valid;
    op_t    req_op;
    haddr_t req_addr;
    hdata_t req_wdata;
    logic   ready;
    logic   rd_valid;
    hdata_t rd_data;

    hdata_t      ref_mem [256];                // Indexed by addr[9:2]
    hdata_t      exp_q [$];                    // Expected read data, in order
    int          stall_cnt;                    // Wait cycles still expected
    logic        dp_pend;                      // Data phase in flight
    logic        dp_rd;                        // ...and it is a read
    logic [31:0] lfsr_state;
    int          cycle_cnt = 0;
    int          n_reads = 0;

    tb_clkgen u_clkgen (.o_clk_ahb(clk_ahb), .o_rstn_ahb(rstn_ahb));

    ahb_subsys_top dut0 (
        .i_clk_ahb  (clk_ahb),
        .i_rstn_ahb (rstn_ahb),
        .i_valid    (req_valid),
        .i_rd0_wr1  (req_op),
        .i_addr     (req_addr),
        .i_wr_data  (req_wdata),
        .o_ready    (ready),
        .o_rd_valid (rd_valid),
        .o_rd_data  (rd_data)
    );

    // **********************************************************************
    // Random numbers and address helpers
    // **********************************************************************
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) n = n ^ 32'h8020_0003;       // Galois taps
        return n;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);  // One step per bit
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic haddr_t make_addr(input logic [`AHB_ADDR_W-11:0] hi,
                                         input logic [1:0] slv,
                                         input logic [5:0] word);
        return {hi, slv, word, 2'b00};         // Bits above 9 alias
    endfunction

    // **********************************************************************
    // Compare tasks
    // **********************************************************************
    task automatic check_data(input string name, input hdata_t got, input hdata_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // Outputs seen mid-cycle hold at the next rising edge
    task automatic check_cycle();
        logic   exp_rdy;
        logic   exp_rv;
        hdata_t exp_d;
        exp_rdy = (stall_cnt == 0);
        exp_rv  = dp_pend && exp_rdy && dp_rd;
        check_flag("o_ready", ready, exp_rdy);
        check_flag("o_rd_valid", rd_valid, exp_rv);
        if (exp_rv) begin
            exp_d = exp_q.pop_front();
            check_data("o_rd_data", rd_data, exp_d);
            n_reads++;
        end
        if (exp_rdy) dp_pend = 1'b0;           // Data phase ends this edge
        if (stall_cnt > 0) stall_cnt--;
    endtask

    // Model update for a request taken at the coming edge
    task automatic accept(input op_t op, input haddr_t a, input hdata_t d);
        if (op == OP_WRITE) ref_mem[a[9:2]] = d;
        else exp_q.push_back(ref_mem[a[9:2]]);
        stall_cnt = int'(a[`AHB_SLV_SEL_LSB +: 2]);  // Slave k stalls k cycles
        dp_pend   = 1'b1;
        dp_rd     = (op == OP_READ);
    endtask

    // Drive on the falling edge, hold until o_ready lets it through
    task automatic issue(input logic v, input op_t op, input haddr_t a, input hdata_t d);
        logic done;
        done = 1'b0;
        while (!done) begin
            @(negedge clk_ahb);
            check_cycle();
            req_valid = v;
            req_op    = op;
            req_addr  = a;
            req_wdata = d;
            if (!v) begin
                done = 1'b1;
            end else if (ready) begin
                accept(op, a, d);
                done = 1'b1;
            end
        end
    endtask

    task automatic random_request(input logic hold_valid);
        logic [31:0] r;
        logic        v;
        op_t         op;
        logic [7:0]  wsel;
        hdata_t      d;
        r    = rand_bits(2);
        v    = hold_valid | (r[1:0] != 2'b00);
        r    = rand_bits(1);
        op   = op_t'(r[0]);
        r    = rand_bits(8);
        wsel = hold_valid ? (r[7:0] & 8'hC3) : r[7:0];  // Few words, more hits
        d    = rand_bits(32);
        issue(v, op, make_addr('0, wsel[7:6], wsel[5:0]), d);
    endtask

    // **********************************************************************
    // Stimulus
    // **********************************************************************
    initial begin
        logic [31:0] r;
        hdata_t      d;
        lfsr_state = 32'd74;
        stall_cnt  = 0;
        dp_pend    = 1'b0;
        dp_rd      = 1'b0;
        req_valid  = 1'b0;
        req_op     = OP_READ;
        req_addr   = '0;
        req_wdata  = '0;
        for (int i = 0; i < 256; i++) ref_mem[i] = '0;

        do begin                               // Idle outputs in reset
            @(negedge clk_ahb);
            check_flag("o_ready", ready, 1'b1);
            check_flag("o_rd_valid", rd_valid, 1'b0);
        end while (!rstn_ahb);

        for (int s = 0; s < `AHB_NUM_SLV; s++) begin   // Unwritten words
            for (int w = 62; w < 64; w++) begin
                r = rand_bits(22);
                issue(1'b1, OP_READ, make_addr(r[21:0], s[1:0], w[5:0]), '0);
            end
        end
        for (int s = 0; s < `AHB_NUM_SLV; s++) begin   // Write then read at once
            d = rand_bits(32);
            issue(1'b1, OP_WRITE, make_addr('0, s[1:0], 6'd5), d);
            issue(1'b1, OP_READ, make_addr('0, s[1:0], 6'd5), '0);
        end
        for (int s = 0; s < `AHB_NUM_SLV; s++) begin   // Aliasing, independence
            for (int w = 8; w < 10; w++) begin
                r = rand_bits(22);
                d = rand_bits(32);
                issue(1'b1, OP_WRITE, make_addr(r[21:0], s[1:0], w[5:0]), d);
            end
            for (int t = 0; t < `AHB_NUM_SLV; t++) begin
                for (int w = 8; w < 10; w++) begin
                    r = rand_bits(22);
                    issue(1'b1, OP_READ, make_addr(r[21:0], t[1:0], w[5:0]), '0);
                end
            end
        end
        repeat (N_RAND) random_request(1'b0);
        repeat (N_B2B) random_request(1'b1);
        repeat (N_DRAIN) issue(1'b0, OP_READ, '0, '0);

        if (exp_q.size() != 0 || dp_pend) begin
            $display("Reads still outstanding after drain: %0d", exp_q.size());
            $display("Simulation failed");
            $fatal(1);
        end else begin
            $display("Reads checked: %0d", n_reads);
            $display("Simulation completed successfully");
            $finish;
        end
    end

    // Run length guard
    always @(posedge clk_ahb) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYC) begin
            $display("Timeout after %0d cycles, traffic did not finish", cycle_cnt);
            $display("Simulation failed");
            $fatal(1);
        end
    end

endmodule

// ==== build.f ====
+incdir+rtl
rtl/ahb_pkg.sv
rtl/xact_pkg.sv
rtl/ahb_if.sv
rtl/ahb_master.sv
rtl/ahb_decoder.sv
rtl/ahb_sram_slave.sv
rtl/ahb_resp_mux.sv
rtl/ahb_subsys_top.sv
tests/tb_clkgen.sv
tests/tb_ahb_subsys.sv

// ==== Makefile ====
# Verilator build and run for the AHB-Lite memory subsystem testbench

TOP = tb_ahb_subsys

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--x-assign 0 --x-initial 0 -j 0 \
		--top-module $(TOP) -Mdir obj_dir -f build.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
